// ==== verilog/soc_pkg.sv ====
// ==============================
// Shared definitions of the system-control block
// Bus widths and slot address map
// Device ids and register offsets
// Bus operation and reset request enums
// ==============================
package soc_pkg;

	// Peripheral bus
	localparam int DATA_W = 32;
	localparam int ADDR_W = 8;

	// Word address splits into slot number and offset inside the slot
	localparam int SLOT_SEL_W = 4;
	localparam int SLOT_OFS_W = 4;

	// Slot map
	localparam int SLOT_DEVTBL = 0;
	localparam int SLOT_GPIO = 1;
	localparam int SLOT_COUNT = 16;

	// Device ids as reported by the device table
	localparam int DEVID_DEVTBL = 7;
	localparam int DEVID_GPIO = 6;
	localparam int DEVID_NONE = 0;

	// Register offsets
	localparam int DEVTBL_RSTREG_OFS = 15;
	localparam int GPIO_IN_OFS = 0;
	localparam int GPIO_OUT_OFS = 1;
	localparam int GPIO_IRQ_OFS = 2;

	localparam int GPIO_W = 8;

	// Reset hold-off, full count of the counter
	localparam int RST_CNTR_W = 4;
	localparam int RST_HOLD_CYCLES = (1 << RST_CNTR_W) - 1;

	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} bus_op_t;

	// Encoding matches data bits 1:0 of a write to the reset register
	typedef enum logic [1:0] {
		RST_NONE     = 2'd0,
		RST_WARM     = 2'd1,
		RST_POWEROFF = 2'd2
	} rst_req_t;

endpackage

// ==== verilog/reset_seq.sv ====
// ==============================
// Reset sequencer
// Hold-off counter for external and warm reset
// Power-off latch
// ==============================
`timescale 1ns/1ps

module reset_seq (
	input  logic              clk_2x_w,
	input  logic              rst_p,
	input  soc_pkg::rst_req_t rst_req_i,
	output logic              soc_rst_o,
	output logic              pwr_off_o
);
	import soc_pkg::*;

	logic [RST_CNTR_W-1:0] rst_cntr_q;
	logic                  pwr_off_q;
	logic                  reload;

	// A warm request behaves like the external reset pin
	assign reload = rst_p || (rst_req_i == RST_WARM);

	always_ff @(posedge clk_2x_w) begin
		if (reload) begin
			rst_cntr_q <= RST_CNTR_W'(RST_HOLD_CYCLES);
		end else if (rst_cntr_q != '0) begin
			rst_cntr_q <= rst_cntr_q - 1'b1;
		end
	end

	// Only the external pin brings the system back from power-off
	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			pwr_off_q <= 1'b0;
		end else if (rst_req_i == RST_POWEROFF) begin
			pwr_off_q <= 1'b1;
		end
	end

	// System reset holds while counting or while powered off
	assign soc_rst_o = (rst_cntr_q != '0) || pwr_off_q;
	assign pwr_off_o = pwr_off_q;

endmodule

// ==== verilog/periph_bus.sv ====
// ==============================
// Peripheral bus
// Slot decode and per-device strobes
// Registered ack and response select
// ==============================
`timescale 1ns/1ps

module periph_bus (
	input  logic                         clk_2x_w,
	input  logic                         soc_rst_i,
	input  logic                         req_i,
	input  soc_pkg::bus_op_t             op_i,
	input  logic [soc_pkg::ADDR_W-1:0]   addr_i,
	input  logic [soc_pkg::DATA_W-1:0]   wdata_i,
	output logic                         ack_o,
	output logic [soc_pkg::DATA_W-1:0]   rdata_o,
	output logic                         devtbl_stb_o,
	output logic                         gpio_stb_o,
	output soc_pkg::bus_op_t             dev_op_o,
	output logic [soc_pkg::SLOT_OFS_W-1:0] dev_ofs_o,
	output logic [soc_pkg::DATA_W-1:0]   dev_wdata_o,
	input  logic [soc_pkg::DATA_W-1:0]   devtbl_rdata_i,
	input  logic [soc_pkg::DATA_W-1:0]   gpio_rdata_i
);
	import soc_pkg::*;

	logic                  accept;
	logic [SLOT_SEL_W-1:0] slot;
	logic [SLOT_SEL_W-1:0] slot_q;
	logic                  rd_q;

	// No request is taken while the system is held in reset
	assign accept = req_i && !soc_rst_i;
	assign slot = addr_i[ADDR_W-1 -: SLOT_SEL_W];

	assign devtbl_stb_o = accept && (slot == SLOT_SEL_W'(SLOT_DEVTBL));
	assign gpio_stb_o = accept && (slot == SLOT_SEL_W'(SLOT_GPIO));
	assign dev_op_o = op_i;
	assign dev_ofs_o = addr_i[SLOT_OFS_W-1:0];
	assign dev_wdata_o = wdata_i;

	always_ff @(posedge clk_2x_w) begin
		if (soc_rst_i) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= accept;
		end
	end

	// Remember where the request went, devices answer one cycle later
	always_ff @(posedge clk_2x_w) begin
		slot_q <= slot;
		rd_q <= (op_i == OP_READ);
	end

	always_comb begin
		rdata_o = '0;
		if (ack_o && rd_q) begin
			case (slot_q)
				SLOT_SEL_W'(SLOT_DEVTBL): rdata_o = devtbl_rdata_i;
				SLOT_SEL_W'(SLOT_GPIO):   rdata_o = gpio_rdata_i;
				// empty slots read as zero
				default:                  rdata_o = '0;
			endcase
		end
	end

endmodule

// ==== verilog/dev_table.sv ====
// ==============================
// Device table
// Read-only id and interrupt use per slot
// Software reset request register
// ==============================
`timescale 1ns/1ps

module dev_table (
	input  logic                           clk_2x_w,
	input  logic                           soc_rst_i,
	input  logic                           stb_i,
	input  soc_pkg::bus_op_t               op_i,
	input  logic [soc_pkg::SLOT_OFS_W-1:0] ofs_i,
	input  logic [soc_pkg::DATA_W-1:0]     wdata_i,
	output logic [soc_pkg::DATA_W-1:0]     rdata_o,
	output soc_pkg::rst_req_t              rst_req_o
);
	import soc_pkg::*;

	logic [DATA_W-1:0] id_tbl [SLOT_COUNT];
	logic [DATA_W-1:0] rd_word;
	logic              rstreg_sel;

	// Bits 15:0 hold the device id, bit 31 flags interrupt use
	always_comb begin
		for (int i = 0; i < SLOT_COUNT; i++) begin
			id_tbl[i] = DATA_W'(DEVID_NONE);
		end
		id_tbl[SLOT_DEVTBL] = DATA_W'(DEVID_DEVTBL);
		// GPIO is the only interrupt source left
		id_tbl[SLOT_GPIO] = {1'b1, 15'd0, 16'(DEVID_GPIO)};
	end

	assign rstreg_sel = (ofs_i == SLOT_OFS_W'(DEVTBL_RSTREG_OFS));

	// The reset register shadows the table entry at its offset
	assign rd_word = rstreg_sel ? DATA_W'(rst_req_o) : id_tbl[ofs_i];

	always_ff @(posedge clk_2x_w) begin
		if (stb_i && (op_i == OP_READ)) begin
			rdata_o <= rd_word;
		end
	end

	// Request is dropped once the system has entered reset
	always_ff @(posedge clk_2x_w) begin
		if (soc_rst_i) begin
			rst_req_o <= RST_NONE;
		end else if (stb_i && (op_i == OP_WRITE) && rstreg_sel) begin
			case (wdata_i[1:0])
				2'd1:    rst_req_o <= RST_WARM;
				2'd2:    rst_req_o <= RST_POWEROFF;
				default: rst_req_o <= RST_NONE;
			endcase
		end
	end

endmodule

// ==== verilog/gpio_port.sv ====
// ==============================
// GPIO port
// Input synchronizer and output register
// Input-change interrupt with read-to-clear
// ==============================
`timescale 1ns/1ps

module gpio_port (
	input  logic                           clk_2x_w,
	input  logic                           soc_rst_i,
	input  logic                           stb_i,
	input  soc_pkg::bus_op_t               op_i,
	input  logic [soc_pkg::SLOT_OFS_W-1:0] ofs_i,
	input  logic [soc_pkg::DATA_W-1:0]     wdata_i,
	output logic [soc_pkg::DATA_W-1:0]     rdata_o,
	input  logic [soc_pkg::GPIO_W-1:0]     gp_i,
	output logic [soc_pkg::GPIO_W-1:0]     gp_o,
	output logic                           irq_o
);
	import soc_pkg::*;

	logic [GPIO_W-1:0] sync1_q;
	logic [GPIO_W-1:0] sync2_q;
	logic [GPIO_W-1:0] prev_q;
	logic              rd_stb;
	logic              wr_stb;

	assign rd_stb = stb_i && (op_i == OP_READ);
	assign wr_stb = stb_i && (op_i == OP_WRITE);

	// Two-stage synchronizer, prev_q follows one cycle behind
	always_ff @(posedge clk_2x_w) begin
		sync1_q <= gp_i;
		sync2_q <= sync1_q;
		prev_q <= sync2_q;
	end

	// A new change wins over a clearing read in the same cycle
	always_ff @(posedge clk_2x_w) begin
		if (soc_rst_i) begin
			irq_o <= 1'b0;
		end else if (sync2_q != prev_q) begin
			irq_o <= 1'b1;
		end else if (rd_stb && (ofs_i == SLOT_OFS_W'(GPIO_IRQ_OFS))) begin
			irq_o <= 1'b0;
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (soc_rst_i) begin
			gp_o <= '0;
		end else if (wr_stb && (ofs_i == SLOT_OFS_W'(GPIO_OUT_OFS))) begin
			gp_o <= wdata_i[GPIO_W-1:0];
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (rd_stb) begin
			case (ofs_i)
				SLOT_OFS_W'(GPIO_IN_OFS):  rdata_o <= DATA_W'(sync2_q);
				SLOT_OFS_W'(GPIO_OUT_OFS): rdata_o <= DATA_W'(gp_o);
				SLOT_OFS_W'(GPIO_IRQ_OFS): rdata_o <= DATA_W'(irq_o);
				default:                   rdata_o <= '0;
			endcase
		end
	end

endmodule

// ==== verilog/soc_top.sv ====
// ==============================
// System-control top level
// Peripheral bus, reset sequencer,
// device table and GPIO port
// ==============================
`timescale 1ns/1ps

module soc_top (
	input  logic                       clk_2x_w,
	input  logic                       rst_p,
	input  logic                       req_i,
	input  soc_pkg::bus_op_t           op_i,
	input  logic [soc_pkg::ADDR_W-1:0] addr_i,
	input  logic [soc_pkg::DATA_W-1:0] wdata_i,
	output logic                       ack_o,
	output logic [soc_pkg::DATA_W-1:0] rdata_o,
	input  logic [soc_pkg::GPIO_W-1:0] gp_i,
	output logic [soc_pkg::GPIO_W-1:0] gp_o,
	output logic                       irq_o,
	output logic                       soc_rst_o,
	output logic                       pwr_off_o
);
	import soc_pkg::*;

	rst_req_t              rst_req;
	logic                  devtbl_stb;
	logic                  gpio_stb;
	bus_op_t               dev_op;
	logic [SLOT_OFS_W-1:0] dev_ofs;
	logic [DATA_W-1:0]     dev_wdata;
	logic [DATA_W-1:0]     devtbl_rdata;
	logic [DATA_W-1:0]     gpio_rdata;

	reset_seq i_reset_seq (
		.clk_2x_w  (clk_2x_w),
		.rst_p     (rst_p),
		.rst_req_i (rst_req),
		.soc_rst_o (soc_rst_o),
		.pwr_off_o (pwr_off_o)
	);

	periph_bus i_periph_bus (
		.clk_2x_w       (clk_2x_w),
		.soc_rst_i      (soc_rst_o),
		.req_i          (req_i),
		.op_i           (op_i),
		.addr_i         (addr_i),
		.wdata_i        (wdata_i),
		.ack_o          (ack_o),
		.rdata_o        (rdata_o),
		.devtbl_stb_o   (devtbl_stb),
		.gpio_stb_o     (gpio_stb),
		.dev_op_o       (dev_op),
		.dev_ofs_o      (dev_ofs),
		.dev_wdata_o    (dev_wdata),
		.devtbl_rdata_i (devtbl_rdata),
		.gpio_rdata_i   (gpio_rdata)
	);

	// Device table also steers the reset sequencer
	dev_table i_dev_table (
		.clk_2x_w  (clk_2x_w),
		.soc_rst_i (soc_rst_o),
		.stb_i     (devtbl_stb),
		.op_i      (dev_op),
		.ofs_i     (dev_ofs),
		.wdata_i   (dev_wdata),
		.rdata_o   (devtbl_rdata),
		.rst_req_o (rst_req)
	);

	gpio_port i_gpio_port (
		.clk_2x_w  (clk_2x_w),
		.soc_rst_i (soc_rst_o),
		.stb_i     (gpio_stb),
		.op_i      (dev_op),
		.ofs_i     (dev_ofs),
		.wdata_i   (dev_wdata),
		.rdata_o   (gpio_rdata),
		.gp_i      (gp_i),
		.gp_o      (gp_o),
		.irq_o     (irq_o)
	);

endmodule

// ==== dv/soc_chk.sv ====
// ==============================
// Checker bound to the top level
// Bus handshake and reset assertions
// ==============================
`timescale 1ns/1ps

module soc_chk (
	input logic                       clk_2x_w,
	input logic                       rst_p,
	input logic                       req_i,
	input logic                       ack_o,
	input logic [soc_pkg::GPIO_W-1:0] gp_o,
	input logic                       irq_o,
	input logic                       soc_rst_o,
	input logic                       pwr_off_o
);
	a_ack_after_req: assert property (@(posedge clk_2x_w) req_i && !soc_rst_o |=> ack_o)
		else $error("ack_o missing after an accepted request");

	// An ack only follows a request taken outside reset
	a_ack_only_after_req: assert property (@(posedge clk_2x_w) disable iff (rst_p)
		ack_o |-> $past(req_i && !soc_rst_o))
		else $error("ack_o without an accepted request");

	a_no_ack_in_reset: assert property (@(posedge clk_2x_w) soc_rst_o |=> !ack_o)
		else $error("ack_o while the system is in reset");

	a_pwr_off_holds: assert property (@(posedge clk_2x_w) pwr_off_o && !rst_p |=> pwr_off_o)
		else $error("pwr_off_o dropped without the reset pin");

	// Devices settle one cycle into reset
	a_quiet_in_reset: assert property (@(posedge clk_2x_w)
		soc_rst_o && $past(soc_rst_o) |-> (gp_o == '0) && !irq_o)
		else $error("gp_o or irq_o active during reset");

endmodule

bind soc_top soc_chk i_soc_chk (
	.clk_2x_w  (clk_2x_w),
	.rst_p     (rst_p),
	.req_i     (req_i),
	.ack_o     (ack_o),
	.gp_o      (gp_o),
	.irq_o     (irq_o),
	.soc_rst_o (soc_rst_o),
	.pwr_off_o (pwr_off_o)
);

// ==== dv/soc_tb.sv ====
// ==============================
// Testbench of the system-control top level
// Clock, reset, LCG stimulus, watchdog
// Value checks and pass/fail report
// ==============================
`timescale 1ns/1ps

module soc_tb;
	import soc_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int GPIO_ROUNDS = 8;
	// Resets, table reads, GPIO accesses and the two software resets
	localparam int NUM_OPS = 3 + SLOT_COUNT + 2 + 5 * GPIO_ROUNDS + 12;
	localparam int OP_BOUND_CYCLES = 2 * RST_HOLD_CYCLES + 10;

	logic              clk_2x_w;
	logic              rst_p;
	logic              req_i;
	bus_op_t           op_i;
	logic [ADDR_W-1:0] addr_i;
	logic [DATA_W-1:0] wdata_i;
	logic              ack_o;
	logic [DATA_W-1:0] rdata_o;
	logic [GPIO_W-1:0] gp_i;
	logic [GPIO_W-1:0] gp_o;
	logic              irq_o;
	logic              soc_rst_o;
	logic              pwr_off_o;
	logic [31:0]       lcg_state;
	logic [DATA_W-1:0] rd;
	logic [GPIO_W-1:0] val;
	int                hold;
	bit                verdict_done;

	soc_top i_soc_top (.*);

	initial begin
		clk_2x_w = 1'b0;
		forever #(CLK_PERIOD / 2) clk_2x_w = ~clk_2x_w;
	end

	initial begin
		#(NUM_OPS * OP_BOUND_CYCLES * CLK_PERIOD);
		verdict_done = 1'b1;
		$display("Watchdog expired before the tests finished");
		$display("Test failed");
		$fatal(1);
	end

	final begin
		if (!verdict_done) begin
			$display("Test failed");
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Id in bits 15:0, bit 31 marks an interrupt user
	function automatic logic [DATA_W-1:0] devtbl_word(input int ofs);
		if (ofs == SLOT_DEVTBL) begin
			return DATA_W'(DEVID_DEVTBL);
		end
		if (ofs == SLOT_GPIO) begin
			return DATA_W'(DEVID_GPIO) | 32'h8000_0000;
		end
		// Reset register reads zero with no request pending
		return DATA_W'(DEVID_NONE);
	endfunction

	task automatic stop_with_error(input string msg);
		verdict_done = 1'b1;
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_eq(input string name, input logic [DATA_W-1:0] got,
			input logic [DATA_W-1:0] exp);
		assert (got === exp) else
			stop_with_error($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
	endtask

	task automatic check_true(input logic cond, input string msg);
		assert (cond === 1'b1) else stop_with_error(msg);
	endtask

	// Inputs change a little after the rising edge
	task automatic next_cycle();
		@(posedge clk_2x_w);
		#2;
	endtask

	task automatic bus_access(input bus_op_t op, input int slot, input int ofs,
			input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
		req_i = 1'b1;
		op_i = op;
		addr_i = {SLOT_SEL_W'(slot), SLOT_OFS_W'(ofs)};
		wdata_i = wdata;
		next_cycle();
		req_i = 1'b0;
		check_true(ack_o, "No ack in the cycle after an accepted request");
		rdata = rdata_o;
		if (op == OP_WRITE) begin
			check_eq("rdata_o", rdata_o, '0);
		end
	endtask

	// Cycles until soc_rst_o falls
	task automatic count_hold(output int n);
		n = 0;
		while (soc_rst_o) begin
			check_eq("ack_o", DATA_W'(ack_o), '0);
			check_eq("pwr_off_o", DATA_W'(pwr_off_o), '0);
			check_true(n < 4 * RST_HOLD_CYCLES, "soc_rst_o was never released");
			next_cycle();
			n++;
		end
		check_eq("gp_o", DATA_W'(gp_o), '0);
		check_eq("irq_o", DATA_W'(irq_o), '0);
	endtask

	task automatic reset_and_check();
		int n;
		rst_p = 1'b1;
		repeat (5) next_cycle();
		rst_p = 1'b0;
		count_hold(n);
		check_eq("soc_rst_o hold cycles", DATA_W'(n), DATA_W'(RST_HOLD_CYCLES));
	endtask

	// Two synchronizer stages plus the compare register
	task automatic gpio_change(input logic [GPIO_W-1:0] v);
		gp_i = v;
		next_cycle();
		next_cycle();
		check_eq("irq_o", DATA_W'(irq_o), '0);
		next_cycle();
		check_eq("irq_o", DATA_W'(irq_o), 32'd1);
	endtask

	initial begin
		rst_p = 1'b1;
		req_i = 1'b0;
		op_i = OP_READ;
		addr_i = '0;
		wdata_i = '0;
		gp_i = '0;
		lcg_state = 32'hfc76_eb05;
		reset_and_check();

		for (int i = 0; i < SLOT_COUNT; i++) begin
			bus_access(OP_READ, SLOT_DEVTBL, i, '0, rd);
			check_eq("rdata_o", rd, devtbl_word(i));
		end
		bus_access(OP_READ, SLOT_DEVTBL, SLOT_DEVTBL, '0, rd);
		check_eq("rdata_o", rd, devtbl_word(SLOT_DEVTBL));
		// Same offset right after a nonzero table word, so aliasing would show
		bus_access(OP_READ, 5, SLOT_DEVTBL, '0, rd);
		check_eq("rdata_o", rd, '0);

		for (int r = 0; r < GPIO_ROUNDS; r++) begin
			lcg_state = lcg_next(lcg_state);
			val = lcg_state[15:8];
			bus_access(OP_WRITE, SLOT_GPIO, GPIO_OUT_OFS, DATA_W'(val), rd);
			check_eq("gp_o", DATA_W'(gp_o), DATA_W'(val));
			bus_access(OP_READ, SLOT_GPIO, GPIO_OUT_OFS, '0, rd);
			check_eq("rdata_o", rd, DATA_W'(val));
			lcg_state = lcg_next(lcg_state);
			val = lcg_state[23:16];
			if (val == gp_i) begin
				val = ~val;
			end
			gpio_change(val);
			bus_access(OP_READ, SLOT_GPIO, GPIO_IN_OFS, '0, rd);
			check_eq("rdata_o", rd, DATA_W'(val));
			bus_access(OP_READ, SLOT_GPIO, GPIO_IRQ_OFS, '0, rd);
			check_eq("rdata_o", rd, 32'd1);
			check_eq("irq_o", DATA_W'(irq_o), '0);
		end

		// Warm reset with gp_o set and an interrupt pending
		bus_access(OP_WRITE, SLOT_GPIO, GPIO_OUT_OFS, 32'h5a, rd);
		gpio_change(~gp_i);
		bus_access(OP_WRITE, SLOT_DEVTBL, DEVTBL_RSTREG_OFS, 32'd1, rd);
		next_cycle();
		check_true(soc_rst_o, "Warm reset request did not raise soc_rst_o");
		count_hold(hold);
		// Request stays registered one cycle into reset, so the counter reloads twice
		check_eq("soc_rst_o hold cycles", DATA_W'(hold), DATA_W'(RST_HOLD_CYCLES + 1));

		bus_access(OP_WRITE, SLOT_DEVTBL, DEVTBL_RSTREG_OFS, 32'd2, rd);
		check_eq("pwr_off_o", DATA_W'(pwr_off_o), '0);
		next_cycle();
		// Requests are ignored while powered off
		req_i = 1'b1;
		op_i = OP_READ;
		addr_i = '0;
		repeat (8) begin
			check_eq("pwr_off_o", DATA_W'(pwr_off_o), 32'd1);
			check_eq("soc_rst_o", DATA_W'(soc_rst_o), 32'd1);
			next_cycle();
			check_eq("ack_o", DATA_W'(ack_o), '0);
		end
		req_i = 1'b0;
		reset_and_check();
		bus_access(OP_READ, SLOT_DEVTBL, SLOT_DEVTBL, '0, rd);
		check_eq("rdata_o", rd, devtbl_word(SLOT_DEVTBL));

		verdict_done = 1'b1;
		$display("Test passed");
		$finish;
	end

endmodule

// ==== sources.f ====
verilog/soc_pkg.sv
verilog/reset_seq.sv
verilog/periph_bus.sv
verilog/dev_table.sv
verilog/gpio_port.sv
verilog/soc_top.sv
dv/soc_chk.sv
dv/soc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module soc_tb -f sources.f -o Vsoc_tb
./obj_dir/Vsoc_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test passed$" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed, see sim.log"
	exit 1
fi
